// File: tb.f
exec_pkg.sv
alu_core.sv
muldiv_ctrl.sv
muldiv_counter.sv
muldiv_datapath.sv
exec_unit.sv
tb_exec.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_exec

output=$(./obj_dir/Vtb_exec)
echo "$output"

if grep -q "ALL TESTS PASSED" <<< "$output"; then
	exit 0
fi
exit 1

// File: tb_exec.sv
module tb_exec;
	timeunit 1ns;
	timeprecision 100ps;
	import exec_pkg::*;

	// Tests take roughly 2000 cycles in total
	localparam int MAX_CYCLES = 4000;
	localparam int WAIT_LIMIT = 64;                // Longest op needs 34 cycles

	logic       clk;
	logic       reset;
	logic       start;
	exec_req_t  req;
	logic       busy;
	logic       result_valid;
	exec_resp_t resp;
	hilo_t      hilo;

	int    errors;
	int    test_errors;
	int    tests_run;
	int    cycle_count = 0;
	string test_name;

	exec_unit uut (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.req          (req),
		.busy         (busy),
		.result_valid (result_valid),
		.resp         (resp),
		.hilo         (hilo)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0)
			$display("%s: done, no mismatches", test_name);
		else
			$display("%s: done, %0d mismatches", test_name, test_errors);
	endtask

	// Pulse start and count cycles until result_valid
	task automatic run_op(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
			output int latency);
		@(posedge clk);
		start  <= 1'b1;
		req.op <= op;
		req.a  <= a;
		req.b  <= b;
		@(posedge clk);
		start   <= 1'b0;
		latency = 0;
		do begin
			@(negedge clk);                    // Outputs settled
			latency++;
		end while (!result_valid && latency < WAIT_LIMIT);
		if (!result_valid) begin
			$display("%s: %s got no result_valid within %0d cycles",
				test_name, op.name(), WAIT_LIMIT);
			errors++;
			test_errors++;
		end
	endtask

	function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (op)
			OP_AND:             return a & b;
			OP_OR:              return a | b;
			OP_XOR:             return a ^ b;
			OP_ADDU:            return a + b;
			OP_SUBU:            return a - b;
			OP_SLTU:            return {31'b0, a < b};
			OP_SLT:             return {31'b0, sa < $signed(b)};
			OP_SLL:             return a << b[10:6];
			OP_SRL:             return a >> b[10:6];
			OP_SRA:             return sa >>> b[10:6];
			OP_SLLV:            return a << b[4:0];
			OP_SRLV:            return a >> b[4:0];
			OP_SRAV:            return sa >>> b[4:0];
			OP_LUI:             return {b[15:0], 16'b0};
			OP_BLTZ, OP_BLTZAL: return (sa < 0) ? 32'd0 : 32'd1;  // Zero when taken
			OP_BGTZ:            return (sa > 0) ? 32'd0 : 32'd1;
			OP_BLEZ:            return (sa <= 0) ? 32'd0 : 32'd1;
			OP_BNEZ:            return (a != 32'd0) ? 32'd0 : 32'd1;
			default:            return 32'd0;
		endcase
	endfunction

	// Returns {HI, LO}
	function automatic logic [63:0] md_ref(input alu_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa32;
		logic signed [31:0] sb32;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		sa32 = a;
		sb32 = b;
		sa   = sa32;                               // Sign extended
		sb   = sb32;
		case (op)
			OP_MULTU: return {32'b0, a} * {32'b0, b};
			OP_MULT:  return sa * sb;
			OP_DIVU:  return {a % b, a / b};
			OP_DIV:   return {sa32 % sb32, sa32 / sb32};  // Truncates toward zero
			default:  return 64'd0;
		endcase
	endfunction

	task automatic alu_case(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] y_exp;
		int          lat;
		y_exp = alu_ref(op, a, b);
		run_op(op, a, b, lat);
		check({op.name(), " y"}, 64'(y_exp), 64'(resp.y));
		check({op.name(), " zero"}, 64'(y_exp == 32'd0), 64'(resp.zero));
		check({op.name(), " latency"}, 64'd1, 64'(lat));
	endtask

	task automatic check_hilo(input logic [63:0] expected);
		int lat;
		check("HILO", expected, hilo);
		run_op(OP_MFHI, 32'd0, 32'd0, lat);
		check("MFHI", 64'(expected[63:32]), 64'(resp.y));
		run_op(OP_MFLO, 32'd0, 32'd0, lat);
		check("MFLO", 64'(expected[31:0]), 64'(resp.y));
	endtask

	task automatic md_case(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
		logic [63:0] expected;
		int          lat;
		expected = md_ref(op, a, b);
		run_op(op, a, b, lat);
		check({op.name(), " latency"}, 64'd34, 64'(lat));
		check_hilo(expected);
	endtask

	task automatic test_logic_arith();
		alu_op_t     ops[7];
		logic [31:0] corner[4];
		ops    = '{OP_AND, OP_OR, OP_XOR, OP_ADDU, OP_SUBU, OP_SLTU, OP_SLT};
		corner = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000};
		begin_test("logic_arith");
		foreach (ops[i]) begin
			for (int r = 0; r < 6; r++) begin
				alu_case(ops[i], $urandom(), $urandom());
			end
			foreach (corner[j]) begin
				alu_case(ops[i], corner[j], corner[(j + 1) % 4]);
			end
		end
		alu_case(OP_XOR, 32'h1234_5678, 32'h1234_5678);  // Zero flag set
		end_test();
	endtask

	task automatic test_shifts();
		alu_op_t     ops[7];
		logic [31:0] vals[3];
		ops  = '{OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV, OP_LUI};
		vals = '{32'h8765_4321, 32'hffff_fff0, $urandom()};
		begin_test("shifts");
		foreach (ops[i]) begin
			foreach (vals[j]) begin
				alu_case(ops[i], vals[j], $urandom());
				alu_case(ops[i], vals[j], 32'h0000_07df);  // Both amounts 31
				alu_case(ops[i], vals[j], 32'h0000_0000);
			end
		end
		end_test();
	endtask

	task automatic test_branches();
		alu_op_t     ops[5];
		logic [31:0] vals[5];
		ops  = '{OP_BLTZ, OP_BLTZAL, OP_BGTZ, OP_BLEZ, OP_BNEZ};
		vals = '{32'hffff_fffb, 32'h0, 32'd7, 32'h8000_0000, 32'h7fff_ffff};
		begin_test("branches");
		foreach (ops[i]) begin
			foreach (vals[j]) begin
				alu_case(ops[i], vals[j], $urandom());
			end
		end
		end_test();
	endtask

	task automatic test_multiply();
		alu_op_t ops[2];
		ops = '{OP_MULTU, OP_MULT};
		begin_test("multiply");
		foreach (ops[i]) begin
			for (int r = 0; r < 5; r++) begin
				md_case(ops[i], $urandom(), $urandom());
			end
			md_case(ops[i], 32'hffff_ffff, 32'hffff_ffff);
			md_case(ops[i], 32'h8000_0000, 32'h8000_0000);
			md_case(ops[i], 32'h8000_0000, 32'h7fff_ffff);
			md_case(ops[i], 32'hffff_fffb, 32'd7);
		end
		end_test();
	endtask

	task automatic test_divide();
		alu_op_t     ops[2];
		logic [31:0] a;
		logic [31:0] b;
		ops = '{OP_DIVU, OP_DIV};
		begin_test("divide");
		foreach (ops[i]) begin
			md_case(ops[i], 32'd100, 32'd7);
			md_case(ops[i], -32'd100, 32'd7);
			md_case(ops[i], 32'd100, -32'd7);
			md_case(ops[i], -32'd100, -32'd7);
			for (int r = 0; r < 4; r++) begin
				a = $urandom() & 32'h7fff_ffff;
				b = ($urandom() & 32'h0000_ffff) | 32'd1;  // Never zero
				md_case(ops[i], r[0] ? -a : a, r[1] ? -b : b);
			end
		end
		md_case(OP_DIV, 32'h8000_0000, 32'd7);
		end_test();
	endtask

	task automatic test_busy();
		logic [63:0] expected;
		int          busy_cycles;
		int          lat;
		expected    = md_ref(OP_MULT, 32'hfff0_1234, 32'h0abc_0007);
		busy_cycles = 0;
		begin_test("busy");
		@(posedge clk);
		start  <= 1'b1;
		req.op <= OP_MULT;
		req.a  <= 32'hfff0_1234;
		req.b  <= 32'h0abc_0007;
		for (lat = 1; lat <= WAIT_LIMIT; lat++) begin
			@(posedge clk);
			start <= (lat == 5);               // Second start mid-multiply
			if (lat == 5) begin
				req.op <= OP_MULTU;
				req.a  <= 32'h1111_1111;
				req.b  <= 32'h2222_2222;
			end
			@(negedge clk);
			if (busy)
				busy_cycles++;
			if (result_valid)
				break;
		end
		check("latency", 64'd34, 64'(lat));
		check("busy cycles", 64'd33, 64'(busy_cycles));
		check_hilo(expected);                      // First result kept
		end_test();
	endtask

	initial begin
		void'($urandom(61));
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		reset       = 1'b1;
		start       = 1'b0;
		req         = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		test_logic_arith();
		test_shifts();
		test_branches();
		test_multiply();
		test_divide();
		test_busy();
		$display("Tests run: %0d, mismatches: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: exec_unit.sv
module exec_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  exec_pkg::exec_req_t  req,
	output logic                 busy,
	output logic                 result_valid,
	output exec_pkg::exec_resp_t resp,
	output exec_pkg::hilo_t      hilo
);
	import exec_pkg::*;

	logic alu_capture;
	logic md_load;
	logic md_step;
	logic md_finish;
	logic last;

	muldiv_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.op           (req.op),
		.last         (last),
		.busy         (busy),
		.result_valid (result_valid),
		.alu_capture  (alu_capture),
		.md_load      (md_load),
		.md_step      (md_step),
		.md_finish    (md_finish)
	);

	// One iteration per operand bit
	muldiv_counter #(
		.STEPS (DATA_W)
	) u_counter (
		.clk   (clk),
		.reset (reset),
		.load  (md_load),
		.step  (md_step),
		.last  (last)
	);

	muldiv_datapath u_md (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.md_load   (md_load),
		.md_step   (md_step),
		.md_finish (md_finish),
		.hilo      (hilo)
	);

	alu_core u_alu (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.alu_capture (alu_capture),
		.hilo        (hilo),
		.resp        (resp)
	);

endmodule

// File: muldiv_datapath.sv
module muldiv_datapath (
	input  logic                clk,
	input  logic                reset,
	input  exec_pkg::exec_req_t req,
	input  logic                md_load,
	input  logic                md_step,
	input  logic                md_finish,
	output exec_pkg::hilo_t     hilo
);
	import exec_pkg::*;

	localparam int MSB = DATA_W - 1;

	logic [2*DATA_W-1:0] acc_q;                    // Product, or {remainder, quotient}
	logic [DATA_W-1:0]   opnd_q;                   // Multiplicand or divisor magnitude
	logic                is_div_q;
	logic                neg_lo_q;                 // Negate product or quotient
	logic                neg_hi_q;                 // Negate remainder
	logic                op_signed;
	logic [DATA_W-1:0]   a_mag;
	logic [DATA_W-1:0]   b_mag;
	logic [DATA_W:0]     mul_sum;
	logic [DATA_W:0]     rem_shift;
	logic [DATA_W:0]     rem_diff;
	logic [2*DATA_W-1:0] acc_next;
	logic [2*DATA_W-1:0] prod_fix;
	logic [DATA_W-1:0]   quo_fix;
	logic [DATA_W-1:0]   rem_fix;

	assign op_signed = (req.op == OP_MULT) || (req.op == OP_DIV);
	assign a_mag     = (op_signed && req.a[MSB]) ? -req.a : req.a;
	assign b_mag     = (op_signed && req.b[MSB]) ? -req.b : req.b;

	// Shift-add multiply adds into the upper half
	assign mul_sum = {1'b0, acc_q[2*DATA_W-1:DATA_W]} + (acc_q[0] ? {1'b0, opnd_q} : '0);

	// Restoring divide tries a subtract on the shifted remainder
	assign rem_shift = acc_q[2*DATA_W-1:MSB];
	assign rem_diff  = rem_shift - {1'b0, opnd_q};

	always_comb begin
		if (is_div_q) begin
			if (rem_diff[DATA_W]) begin
				acc_next = {rem_shift[MSB:0], acc_q[MSB-1:0], 1'b0};  // Borrow so restore
			end else begin
				acc_next = {rem_diff[MSB:0], acc_q[MSB-1:0], 1'b1};
			end
		end else begin
			acc_next = {mul_sum, acc_q[MSB:1]};
		end
	end

	assign prod_fix = neg_lo_q ? -acc_q : acc_q;
	assign quo_fix  = neg_lo_q ? -acc_q[MSB:0] : acc_q[MSB:0];
	assign rem_fix  = neg_hi_q ? -acc_q[2*DATA_W-1:DATA_W] : acc_q[2*DATA_W-1:DATA_W];

	always_ff @(posedge clk) begin
		if (md_load) begin
			acc_q  <= {{DATA_W{1'b0}}, a_mag};
			opnd_q <= b_mag;
		end else if (md_step) begin
			acc_q <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			is_div_q <= 1'b0;
			neg_lo_q <= 1'b0;
			neg_hi_q <= 1'b0;
			hilo     <= '0;
		end else begin
			if (md_load) begin
				is_div_q <= (req.op == OP_DIV) || (req.op == OP_DIVU);
				neg_lo_q <= op_signed && (req.a[MSB] ^ req.b[MSB]);
				neg_hi_q <= op_signed && req.a[MSB];    // Remainder follows dividend
			end
			if (md_finish) begin
				if (is_div_q) begin
					hilo.hi <= rem_fix;
					hilo.lo <= quo_fix;
				end else begin
					hilo <= prod_fix;
				end
			end
		end
	end

endmodule

// File: muldiv_counter.sv
module muldiv_counter #(
	parameter int STEPS = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic step,
	output logic last
);

	localparam int CNT_W = $clog2(STEPS + 1);

	logic [CNT_W-1:0] count_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
		end else if (load) begin
			count_q <= CNT_W'(STEPS);              // Preset for a new operation
		end else if (step && (count_q != '0)) begin
			count_q <= count_q - 1'b1;
		end
	end

	// Count of one marks the final iteration
	assign last = step && (count_q == CNT_W'(1));

endmodule

// File: muldiv_ctrl.sv
module muldiv_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  exec_pkg::alu_op_t op,
	input  logic              last,
	output logic              busy,
	output logic              result_valid,
	output logic              alu_capture,
	output logic              md_load,
	output logic              md_step,
	output logic              md_finish
);
	import exec_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FIX
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   accept;
	logic   is_md;

	assign accept = start && (state_q == IDLE);   // Starts while busy are dropped
	assign is_md  = (op == OP_MULT) || (op == OP_MULTU) ||
	                (op == OP_DIV)  || (op == OP_DIVU);

	assign alu_capture = accept && !is_md;
	assign md_load     = accept && is_md;
	assign md_step     = (state_q == RUN);
	assign md_finish   = (state_q == FIX);
	assign busy        = (state_q != IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (md_load)
					state_d = RUN;
			end
			RUN: begin
				if (last)
					state_d = FIX;                 // Final iteration this cycle
			end
			FIX:     state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q      <= IDLE;
			result_valid <= 1'b0;
		end else begin
			state_q      <= state_d;
			result_valid <= alu_capture || md_finish;  // One cycle after the write
		end
	end

endmodule

// File: alu_core.sv
module alu_core (
	input  logic                 clk,
	input  logic                 reset,
	input  exec_pkg::exec_req_t  req,
	input  logic                 alu_capture,
	input  exec_pkg::hilo_t      hilo,
	output exec_pkg::exec_resp_t resp
);
	import exec_pkg::*;

	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [4:0]        shamt_imm;
	logic [4:0]        shamt_var;
	logic              a_neg;
	logic              a_is_zero;
	logic [DATA_W-1:0] y_next;

	assign a         = req.a;
	assign b         = req.b;
	assign shamt_imm = b[10:6];                    // Shamt field of the instruction
	assign shamt_var = b[4:0];
	assign a_neg     = a[DATA_W-1];
	assign a_is_zero = (a == '0);

	always_comb begin
		y_next = '0;
		case (req.op)
			OP_AND:  y_next = a & b;
			OP_OR:   y_next = a | b;
			OP_XOR:  y_next = a ^ b;
			OP_ADDU: y_next = a + b;
			OP_SUBU: y_next = a - b;
			OP_SLTU: y_next = {{(DATA_W-1){1'b0}}, (a < b)};
			OP_SLT:  y_next = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
			OP_SLL:  y_next = a << shamt_imm;
			OP_SLLV: y_next = a << shamt_var;
			OP_SRA:  y_next = $unsigned($signed(a) >>> shamt_imm);
			OP_SRL:  y_next = a >> shamt_imm;
			OP_SRAV: y_next = $unsigned($signed(a) >>> shamt_var);
			OP_SRLV: y_next = a >> shamt_var;
			OP_MFHI: y_next = hilo.hi;
			OP_MFLO: y_next = hilo.lo;
			OP_LUI:  y_next = b << 16;
			// Branch compares give 0 when taken
			OP_BLTZ, OP_BLTZAL: begin
				y_next = a_neg ? '0 : DATA_W'(1);
			end
			OP_BGTZ: begin
				y_next = (!a_neg && !a_is_zero) ? '0 : DATA_W'(1);
			end
			OP_BLEZ: begin
				y_next = (a_neg || a_is_zero) ? '0 : DATA_W'(1);
			end
			OP_BNEZ: begin
				y_next = !a_is_zero ? '0 : DATA_W'(1);
			end
			default: y_next = '0;                  // Mul/div ops never captured here
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			resp <= '0;
		end else if (alu_capture) begin
			resp.y    <= y_next;
			resp.zero <= (y_next == '0);
		end
	end

endmodule

// File: exec_pkg.sv
package exec_pkg;

	localparam int DATA_W = 32;                    // MIPS word width

	typedef enum logic [4:0] {
		OP_AND    = 5'b00000,
		OP_OR     = 5'b00001,
		OP_XOR    = 5'b00010,
		OP_ADDU   = 5'b00011,
		OP_SUBU   = 5'b00100,
		OP_SLTU   = 5'b00101,
		OP_SLT    = 5'b00110,
		OP_MULTU  = 5'b00111,                      // Writes HI/LO
		OP_MULT   = 5'b01000,                      // Writes HI/LO
		OP_SLL    = 5'b01001,                      // Amount in b[10:6]
		OP_SLLV   = 5'b01010,                      // Amount in b[4:0]
		OP_SRA    = 5'b01011,
		OP_SRL    = 5'b01100,
		OP_SRAV   = 5'b01101,
		OP_SRLV   = 5'b01110,
		OP_DIV    = 5'b01111,                      // Writes HI/LO
		OP_DIVU   = 5'b10000,                      // Writes HI/LO
		OP_MFHI   = 5'b10001,
		OP_MFLO   = 5'b10010,
		OP_LUI    = 5'b10011,
		OP_BLTZ   = 5'b10100,
		OP_BLTZAL = 5'b10101,                      // Link write handled elsewhere
		OP_BGTZ   = 5'b10110,
		OP_BLEZ   = 5'b10111,
		OP_BNEZ   = 5'b11000
	} alu_op_t;

	// Operation request presented with start
	typedef struct packed {
		alu_op_t             op;
		logic [DATA_W-1:0]   a;
		logic [DATA_W-1:0]   b;
	} exec_req_t;

	typedef struct packed {
		logic [DATA_W-1:0]   y;
		logic                zero;                 // Set when y is zero
	} exec_resp_t;

	// HI holds the upper product word or the remainder
	typedef struct packed {
		logic [DATA_W-1:0]   hi;
		logic [DATA_W-1:0]   lo;
	} hilo_t;

endpackage
